// File: filelist.f
hw/matdet_pkg.sv
hw/hamming_decoder.sv
hw/matdet_input.sv
hw/matdet_ctrl.sv
hw/minor2_unit.sv
hw/minor3_unit.sv
hw/result_assembler.sv
hw/matdet_top.sv
test/matdet_checker.sv
test/matdet_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the matrix minor testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module matdet_tb \
    -f filelist.f -o matdet_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/matdet_sim +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/matdet_tb.sv
//==========================================================================
// testbench for the matrix minor calculator: stimulus table, hamming
// encoder, determinant reference model, checks and report
//==========================================================================
module matdet_tb
    import matdet_pkg::*;
();

    localparam int N_TESTS      = 13;
    localparam int MAX_WAIT     = 12;
    localparam int SRC_IDENT    = 0;
    localparam int SRC_PATTERN  = 1;
    localparam int SRC_EXTREME  = 2;
    localparam int SRC_RANDOM   = 3;
    localparam int SRC_RAND_EXT = 4;
    localparam int ERR_RANDOM   = -1;

    typedef struct packed {
        logic [MODE_W-1:0] mode;
        int                src;
        int                err_pos;
        bit                noise;
        int                gap;
    } test_row_t;

    // mode, matrix source, flipped code bit (0 none), stray in_valid, idle cycles before
    localparam test_row_t TESTS [N_TESTS] = '{
        '{MODE_SIZE2, SRC_IDENT,    0,          1'b0, 2},
        '{MODE_SIZE2, SRC_PATTERN,  0,          1'b0, 0},
        '{MODE_SIZE2, SRC_PATTERN,  ERR_RANDOM, 1'b0, 0},
        '{MODE_SIZE3, SRC_RANDOM,   0,          1'b0, 3},
        '{MODE_SIZE3, SRC_EXTREME,  0,          1'b0, 0},
        '{MODE_SIZE3, SRC_RAND_EXT, 0,          1'b0, 0},
        '{MODE_SIZE3, SRC_RAND_EXT, ERR_RANDOM, 1'b0, 1},
        '{5'b10110,   SRC_PATTERN,  0,          1'b0, 0},
        '{5'b01011,   SRC_RANDOM,   0,          1'b1, 0},
        '{MODE_SIZE2, SRC_RANDOM,   0,          1'b1, 0},
        '{MODE_SIZE3, SRC_RANDOM,   0,          1'b1, 0},
        '{MODE_SIZE2, SRC_RAND_EXT, 3,          1'b0, 0},
        '{MODE_SIZE2, SRC_RANDOM,   ERR_RANDOM, 1'b1, 0}
    };

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [ELEM_CODE_W-1:0] in_data;
    logic [MODE_CODE_W-1:0] in_mode;
    logic                   out_valid;
    logic [OUT_W-1:0]       out_data;
    int                     errors;
    int                     checks;

    matdet_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    bind matdet_top matdet_checker checker_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (N_TESTS * 30) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", N_TESTS * 30);
        $display("Checks failed");
        $finish;
    end

    //==========================================================================
    // encoding and reference model
    //==========================================================================
    // data bits at non power-of-two positions, position 1 is the msb
    function automatic logic [ELEM_CODE_W-1:0] hamming_encode(input int value,
                                                              input int data_w,
                                                              input int code_w);
        logic [ELEM_CODE_W-1:0] word;
        int                     k;
        int                     syn;
        word = '0;
        k    = data_w - 1;
        syn  = 0;
        for (int pos = 1; pos <= code_w; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (((value >> k) & 1) != 0) begin
                    word[code_w-pos] = 1'b1;
                    syn ^= pos;
                end
                k--;
            end
        end
        // parity bits cancel the syndrome of the data bits
        for (int j = 0; j < 4; j++) begin
            if (((syn >> j) & 1) != 0) begin
                word[code_w-(1<<j)] = 1'b1;
            end
        end
        return word;
    endfunction

    function automatic logic [ELEM_CODE_W-1:0] corrupt(input logic [ELEM_CODE_W-1:0] word,
                                                       input int code_w, input int err_pos);
        int pos;
        if (err_pos == 0) begin
            return word;
        end
        pos = (err_pos > 0) ? (err_pos - 1) % code_w + 1 : 1 + int'($urandom % code_w);
        word[code_w-pos] = ~word[code_w-pos];
        return word;
    endfunction

    function automatic void fill_matrix(input int src, output int m [N_ELEM]);
        for (int i = 0; i < N_ELEM; i++) begin
            case (src)
                SRC_IDENT:   m[i] = (i % 5 == 0) ? 1 : 0;
                SRC_PATTERN: m[i] = (i * i * 37) % 201 - 100;
                SRC_EXTREME: m[i] = (((i * 7) % 5) < 2) ? -1024 : 1023;
                SRC_RANDOM:  m[i] = int'($urandom % 2048) - 1024;
                default: begin
                    case ($urandom % 4)
                        0:       m[i] = -1024;
                        1:       m[i] = 1023;
                        default: m[i] = int'($urandom % 2048) - 1024;
                    endcase
                end
            endcase
        end
    endfunction

    // rule of sarrus on the window at row r0, column c0
    function automatic longint det3_ref(input int m [N_ELEM], input int r0, input int c0);
        longint a [3][3];
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                a[i][j] = m[4*(r0+i)+c0+j];
            end
        end
        return a[0][0] * a[1][1] * a[2][2] + a[0][1] * a[1][2] * a[2][0]
             + a[0][2] * a[1][0] * a[2][1] - a[0][2] * a[1][1] * a[2][0]
             - a[0][0] * a[1][2] * a[2][1] - a[0][1] * a[1][0] * a[2][2];
    endfunction

    // field 0 at the msb end in both layouts
    function automatic logic [OUT_W-1:0] expected_word(input logic [MODE_W-1:0] mode,
                                                       input int m [N_ELEM]);
        logic [OUT_W-1:0] word;
        longint           v;
        int               r;
        int               c;
        word = '0;
        if (mode == MODE_SIZE2) begin
            for (int f = 0; f < 9; f++) begin
                r = f / 3;
                c = f % 3;
                v = longint'(m[4*r+c]) * m[4*r+5+c] - longint'(m[4*r+c+1]) * m[4*r+4+c];
                word[OUT_W-1-DET2_W*f -: DET2_W] = v[DET2_W-1:0];
            end
        end else if (mode == MODE_SIZE3) begin
            for (int k = 0; k < 4; k++) begin
                v = det3_ref(m, k / 2, k % 2);
                word[OUT_W-1-DET3_PAD_W-DET3_FIELD_W*k -: DET3_FIELD_W] = v[DET3_FIELD_W-1:0];
            end
        end
        return word;
    endfunction

    //==========================================================================
    // test sequence
    //==========================================================================
    task automatic check_quiet(input int t);
        checks++;
        assert (!out_valid && out_data == '0) else begin
            $display("ERR t=%0t: test %0d output active outside its result cycle", $time, t);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        test_row_t              row;
        int                     m [N_ELEM];
        logic [OUT_W-1:0]       expected;
        logic [OUT_W-1:0]       got;
        logic [MODE_CODE_W-1:0] mode_word;
        int                     exp_lat;
        int                     lat;
        int                     err_before;
        bit                     seen;

        row        = TESTS[t];
        err_before = errors;
        got        = '0;
        fill_matrix(row.src, m);
        expected   = expected_word(row.mode, m);
        // pulse follows the 16th sampling edge by the step count plus one
        exp_lat    = (row.mode == MODE_SIZE2) ? 4 : (row.mode == MODE_SIZE3) ? 5 : 2;
        repeat (row.gap) begin
            @(negedge clk);
            check_quiet(t);
        end
        mode_word = MODE_CODE_W'(corrupt(hamming_encode(int'(row.mode), MODE_W, MODE_CODE_W),
                                         MODE_CODE_W, row.err_pos));
        for (int i = 0; i < N_ELEM; i++) begin
            @(negedge clk);
            check_quiet(t);
            in_valid = 1'b1;
            in_data  = corrupt(hamming_encode(m[i], ELEM_W, ELEM_CODE_W), ELEM_CODE_W,
                               row.err_pos);
            // mode only counts with the first element
            in_mode  = (i == 0) ? mode_word : MODE_CODE_W'($urandom);
        end

        // lat counts edges after the one that samples the last element
        lat  = -1;
        seen = 1'b0;
        while (!seen && lat < MAX_WAIT) begin
            @(negedge clk);
            lat++;
            if (out_valid) begin
                seen = 1'b1;
                got  = out_data;
            end else begin
                checks++;
                assert (out_data == '0) else begin
                    $display("ERR t=%0t: test %0d out_data nonzero before the pulse", $time, t);
                    errors++;
                end
                // stray pulses while busy
                in_valid = row.noise && ($urandom % 2 == 0);
                in_data  = ELEM_CODE_W'($urandom);
            end
        end
        in_valid = 1'b0;

        if (!seen) begin
            $display("test %0d: no out_valid pulse within %0d cycles of the last element",
                     t, MAX_WAIT);
            errors++;
        end else begin
            checks += 2;
            assert (lat == exp_lat) else begin
                $display("ERR t=%0t: test %0d out_valid after %0d cycles, expected %0d",
                         $time, t, lat, exp_lat);
                errors++;
            end
            assert (got == expected) else begin
                $display("ERR t=%0t: test %0d out_data %h, expected %h",
                         $time, t, got, expected);
                errors++;
            end
        end
        $display("test %0d: mode %b source %0d latency %0d %s", t, row.mode, row.src, lat,
                 (errors == err_before) ? "ok" : "wrong");
    endtask

    initial begin
        void'($urandom(32'h24b2));
        errors   = 0;
        checks   = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        @(negedge clk);
        check_quiet(N_TESTS - 1);
        // protocol assertions of the bound checker
        errors += dut_i.checker_i.fail_count;
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: test/matdet_checker.sv
//==========================================================================
// bound assertions on the result output protocol
//==========================================================================
module matdet_checker
    import matdet_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input logic             out_valid,
    input logic [OUT_W-1:0] out_data
);

    // failed assertions so far
    int fail_count;

    // result pulse lasts one cycle
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
    ) else begin
        $error("out_valid stayed high for two cycles");
        fail_count++;
    end

    // output word is quiet between pulses
    a_quiet_data: assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid |-> out_data == '0
    ) else begin
        $error("out_data nonzero while out_valid is low");
        fail_count++;
    end

    a_reset_low: assert property (
        @(posedge clk) $rose(rst_n) |-> !out_valid
    ) else begin
        $error("out_valid high on the first edge after reset");
        fail_count++;
    end

endmodule

// File: hw/matdet_top.sv
//==========================================================================
// top level of the matrix minor calculator
//==========================================================================
module matdet_top
    import matdet_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [ELEM_CODE_W-1:0] in_data,
    input  logic [MODE_CODE_W-1:0] in_mode,
    output logic                   out_valid,
    output logic [OUT_W-1:0]       out_data
);

    md_ctrl_t                 ctrl;
    logic [MODE_W-1:0]        mode;
    matrix_t                  matrix;
    logic                     done_valid;
    logic signed [DET2_W-1:0] det2 [3];
    logic signed [DET3_W-1:0] det3;

    matdet_input input_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_data (in_data),
        .in_mode (in_mode),
        .ctrl    (ctrl),
        .mode    (mode),
        .matrix  (matrix)
    );

    matdet_ctrl ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mode      (mode),
        .ctrl      (ctrl),
        .out_valid (done_valid)
    );

    minor2_unit minor2_i (
        .matrix (matrix),
        .step   (ctrl.step),
        .det    (det2)
    );

    minor3_unit minor3_i (
        .matrix (matrix),
        .step   (ctrl.step),
        .det    (det3)
    );

    result_assembler asm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .out_valid_in (done_valid),
        .det2         (det2),
        .det3         (det3),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

endmodule

// File: hw/result_assembler.sv
//==========================================================================
// result register: collects step results and drives the output word
//==========================================================================
module result_assembler
    import matdet_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  md_ctrl_t                 ctrl,
    input  logic                     out_valid_in,
    input  logic signed [DET2_W-1:0] det2 [3],
    input  logic signed [DET3_W-1:0] det3,
    output logic                     out_valid,
    output logic [OUT_W-1:0]         out_data
);

    md_result_u result;

    //==========================================================================
    // step write-back
    //==========================================================================
    always_ff @(posedge clk) begin
        if (ctrl.clear) begin
            result <= '0;
        end else if (ctrl.calc) begin
            case (ctrl.kind)
                KIND_DET2: begin
                    // one row pair fills three consecutive fields
                    for (int i = 0; i < 3; i++) begin
                        result.det2[int'(ctrl.step)*3+i] <= det2[i];
                    end
                end
                KIND_DET3: begin
                    result.det3.field[ctrl.step] <= DET3_FIELD_W'(det3);
                end
                default: ;
            endcase
        end
    end

    //==========================================================================
    // output
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= out_valid_in;
        end
    end

    // zero outside the valid cycle
    assign out_data = out_valid ? result : '0;

endmodule

// File: hw/minor3_unit.sv
//==========================================================================
// one 3x3 corner determinant per step, first-row cofactor expansion
//==========================================================================
module minor3_unit
    import matdet_pkg::*;
(
    input  matrix_t                  matrix,
    input  logic [1:0]               step,
    output logic signed [DET3_W-1:0] det
);

    always_comb begin
        int                       base;
        elem_t                    w [3][3];
        logic signed [DET3_W-1:0] t0;
        logic signed [DET3_W-1:0] t1;
        logic signed [DET3_W-1:0] t2;

        // step bit 1 picks the top row, bit 0 the left column
        base = int'(step[1]) * 4 + int'(step[0]);
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                w[i][j] = matrix[base+4*i+j];
            end
        end

        t0 = w[0][0] * det2x2(w[1][1], w[1][2], w[2][1], w[2][2]);
        t1 = w[0][1] * det2x2(w[1][0], w[1][2], w[2][0], w[2][2]);
        t2 = w[0][2] * det2x2(w[1][0], w[1][1], w[2][0], w[2][1]);

        // alternating cofactor signs
        det = t0 - t1 + t2;
    end

endmodule

// File: hw/minor2_unit.sv
//==========================================================================
// three adjacent-column 2x2 determinants of one row pair per step
//==========================================================================
module minor2_unit
    import matdet_pkg::*;
(
    input  matrix_t                  matrix,
    input  logic [1:0]               step,
    output logic signed [DET2_W-1:0] det [3]
);

    always_comb begin
        int base;
        // only row pairs 0..2 exist
        base = (step == 2'd3) ? 8 : int'(step) * 4;
        for (int c = 0; c < 3; c++) begin
            det[c] = det2x2(matrix[base+c],     matrix[base+c+1],
                            matrix[base+4+c],   matrix[base+5+c]);
        end
    end

endmodule

// File: hw/matdet_ctrl.sv
//==========================================================================
// controller FSM: element loading, computation steps and the done pulse
//==========================================================================
module matdet_ctrl
    import matdet_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic [MODE_W-1:0] mode,
    output md_ctrl_t          ctrl,
    output logic              out_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_CALC,
        S_DONE
    } state_e;

    state_e     state;
    // element count while loading, step index while computing
    logic [3:0] cnt;
    calc_kind_e kind;
    logic [1:0] last_step;

    // unit and step count per mode, unknown codes get one empty step
    always_comb begin
        case (mode)
            MODE_SIZE2: begin
                kind      = KIND_DET2;
                last_step = 2'd2;
            end
            MODE_SIZE3: begin
                kind      = KIND_DET3;
                last_step = 2'd3;
            end
            default: begin
                kind      = KIND_NONE;
                last_step = 2'd0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_valid) begin
                        state <= S_LOAD;
                        cnt   <= 4'd1;
                    end
                end
                S_LOAD: begin
                    if (in_valid) begin
                        // wraps to zero on the 16th element
                        cnt <= cnt + 4'd1;
                        if (cnt == 4'd15) begin
                            state <= S_CALC;
                        end
                    end
                end
                S_CALC: begin
                    if (cnt[1:0] == last_step) begin
                        state <= S_DONE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                default: begin
                    // second done cycle covers the registered out_valid
                    if (cnt[0]) begin
                        state <= S_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
            endcase
        end
    end

    always_comb begin
        ctrl      = '0;
        ctrl.kind = KIND_NONE;
        case (state)
            S_IDLE: begin
                ctrl.load         = in_valid;
                ctrl.capture_mode = in_valid;
                ctrl.clear        = in_valid;
            end
            S_LOAD: begin
                ctrl.load = in_valid;
            end
            S_CALC: begin
                ctrl.calc = 1'b1;
                ctrl.kind = kind;
                ctrl.step = cnt[1:0];
            end
            default: begin
                ctrl.load = 1'b0;
            end
        endcase
    end

    assign out_valid = (state == S_DONE) && !cnt[0];

endmodule

// File: hw/matdet_input.sv
//==========================================================================
// input stage: decodes the element and mode code words, latches the mode
// and shifts elements into the 16-entry matrix buffer
//==========================================================================
module matdet_input
    import matdet_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [ELEM_CODE_W-1:0] in_data,
    input  logic [MODE_CODE_W-1:0] in_mode,
    input  md_ctrl_t               ctrl,
    output logic [MODE_W-1:0]      mode,
    output matrix_t                matrix
);

    logic [ELEM_W-1:0] elem_dec;
    logic [MODE_W-1:0] mode_dec;

    hamming_decoder #(
        .DATA_W (ELEM_W)
    ) elem_dec_i (
        .code (in_data),
        .data (elem_dec)
    );

    hamming_decoder #(
        .DATA_W (MODE_W)
    ) mode_dec_i (
        .code (in_mode),
        .data (mode_dec)
    );

    // mode arrives with the first element only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= '0;
        end else if (ctrl.capture_mode) begin
            mode <= mode_dec;
        end
    end

    // newest element enters at the top, the first one ends up at index 0
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            matrix <= {elem_t'(elem_dec), matrix[N_ELEM-1:1]};
        end
    end

endmodule

// File: hw/hamming_decoder.sv
//==========================================================================
// single-error-correcting hamming decoder, data width set by parameter
//==========================================================================
module hamming_decoder #(
    parameter  int DATA_W = 11,
    // enough parity bits to number every position of the code word
    localparam int PAR_W  = $clog2(DATA_W + $clog2(DATA_W) + 1),
    localparam int CODE_W = DATA_W + PAR_W
) (
    input  logic [CODE_W-1:0] code,
    output logic [DATA_W-1:0] data
);

    logic [PAR_W-1:0]  syndrome;
    logic [CODE_W-1:0] fixed;

    // position 1 is the msb of the code word
    always_comb begin
        syndrome = '0;
        for (int i = 1; i <= CODE_W; i++) begin
            if (code[CODE_W-i]) begin
                syndrome ^= PAR_W'(i);
            end
        end
    end

    // flip the bit the syndrome points at, if it lies inside the word
    always_comb begin
        fixed = code;
        if (syndrome != '0 && int'(syndrome) <= CODE_W) begin
            fixed[CODE_W-int'(syndrome)] ^= 1'b1;
        end
    end

    // data bits are the non power-of-two positions, first one is the msb
    always_comb begin
        int k;
        k    = DATA_W - 1;
        data = '0;
        for (int i = 1; i <= CODE_W; i++) begin
            if ((i & (i - 1)) != 0) begin
                data[k] = fixed[CODE_W-i];
                k--;
            end
        end
    end

endmodule

// File: hw/matdet_pkg.sv
//==========================================================================
// shared widths, mode codes, controller struct and result union
// plus the signed 2x2 determinant used by both minor units
//==========================================================================
package matdet_pkg;

    //==========================================================================
    // widths
    //==========================================================================
    localparam int ELEM_W       = 11;
    localparam int ELEM_CODE_W  = 15;
    localparam int MODE_W       = 5;
    localparam int MODE_CODE_W  = 9;
    localparam int N_ELEM       = 16;
    localparam int DET2_W       = 23;
    localparam int DET3_W       = 34;
    localparam int DET3_FIELD_W = 51;
    localparam int OUT_W        = 207;
    // leftover bits above the four 3x3 fields
    localparam int DET3_PAD_W   = OUT_W - 4 * DET3_FIELD_W;

    // decoded mode codes
    localparam logic [MODE_W-1:0] MODE_SIZE2 = 5'b00100;
    localparam logic [MODE_W-1:0] MODE_SIZE3 = 5'b00110;

    //==========================================================================
    // types
    //==========================================================================
    typedef logic signed [ELEM_W-1:0] elem_t;

    // row-major, index 0 is row 0 column 0
    typedef elem_t [N_ELEM-1:0] matrix_t;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_DET2,
        KIND_DET3
    } calc_kind_e;

    typedef struct packed {
        logic       load;
        logic       capture_mode;
        logic       calc;
        calc_kind_e kind;
        logic [1:0] step;
        logic       clear;
    } md_ctrl_t;

    typedef struct packed {
        logic [DET3_PAD_W-1:0]          pad;
        logic [0:3][DET3_FIELD_W-1:0]   field;
    } det3_view_t;

    // field 0 sits at the msb end in both views
    typedef union packed {
        logic [0:8][DET2_W-1:0] det2;
        det3_view_t             det3;
    } md_result_u;

    // a*d - b*c, products widened before the subtract
    function automatic logic signed [DET2_W-1:0] det2x2(elem_t a, elem_t b, elem_t c, elem_t d);
        logic signed [DET2_W-1:0] ad;
        logic signed [DET2_W-1:0] bc;
        ad = a * d;
        bc = b * c;
        return ad - bc;
    endfunction

endpackage
